// ==== include/ew_config.svh ====
`ifndef EW_CONFIG_SVH
`define EW_CONFIG_SVH

// lane geometry
`define EW_LANES      8
`define EW_ELEM_W     8
`define EW_WORD_W     64

// sram addressing and counters
`define EW_ADDR_W     13
`define EW_CNT_W      32
`define EW_ADDR_STEP  8

// pipeline latencies in cycles
`define EW_QM_LAT     2
`define EW_ADDSUB_LAT 6
`define EW_MUL_LAT    4

`endif

// ==== design/ew_data_pkg.sv ====
`include "ew_config.svh"

package ew_data_pkg;

    // one int8 element of a lane
    typedef logic signed [`EW_ELEM_W-1:0] elem_t;

    // eight lanes packed, lane 0 in the low byte
    typedef logic [`EW_WORD_W-1:0] word_t;

    // sram read address
    typedef logic [`EW_ADDR_W-1:0] addr_t;

    // beat and result counters
    typedef logic [`EW_CNT_W-1:0] cnt_t;

    // element-wise operation of a run
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2,
        OP_MUL  = 2'd3
    } ew_op_e;

endpackage

// ==== design/ew_quant_pkg.sv ====
package ew_quant_pkg;

    // fixed-point multiplier, q31
    typedef logic signed [31:0] qmult_t;

    // positive shifts left, negative shifts right
    typedef logic signed [31:0] qshift_t;

    // zero-point offsets and 32-bit intermediates
    typedef logic signed [31:0] qoffset_t;

    // activation limits
    typedef logic signed [31:0] qlimit_t;

    // full product of two 32-bit values
    typedef logic signed [63:0] qwide_t;

    localparam qoffset_t QINT_MIN = 32'sh8000_0000;
    localparam qoffset_t QINT_MAX = 32'sh7fff_ffff;

    // clamp to the activation window
    function automatic qlimit_t clamp_act(qoffset_t v, qlimit_t lo, qlimit_t hi);
        if (v < lo) begin
            return lo;
        end else if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

endpackage

// ==== design/quant_mult.sv ====
`timescale 1ns/100ps

module quant_mult
    import ew_quant_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,
    input  qoffset_t x_i,
    input  qmult_t   mult_i,
    input  qshift_t  shift_i,
    output logic     valid_o,
    output qoffset_t y_o
);

    localparam qwide_t NUDGE_POS = 64'sd1073741824;
    localparam qwide_t NUDGE_NEG = -64'sd1073741823;
    localparam qwide_t TRUNC_BIAS = 64'sh0000_0000_7fff_ffff;

    qoffset_t x_shl;
    qwide_t   prod;

    logic     s1_valid;
    qwide_t   s1_prod;
    logic     s1_sat;
    logic [4:0] s1_rsh;

    qwide_t   biased;
    qoffset_t high;
    qoffset_t mask;
    qoffset_t rem;
    qoffset_t thresh;
    qoffset_t rounded;

    // ------------------------------------------------------------------------
    // stage 1: left shift and nudged product
    // ------------------------------------------------------------------------
    always_comb begin
        x_shl = (shift_i > 0) ? (x_i <<< shift_i[4:0]) : x_i;
        prod  = qwide_t'(x_shl) * qwide_t'(mult_i);
    end

    always_ff @(posedge clk) begin
        s1_prod <= prod + ((prod >= 0) ? NUDGE_POS : NUDGE_NEG);
        s1_sat  <= (x_shl == QINT_MIN) && (mult_i == QINT_MIN);
        s1_rsh  <= (shift_i < 0) ? 5'(-shift_i) : 5'd0;
    end

    // ------------------------------------------------------------------------
    // stage 2: high half, then rounding right shift
    // ------------------------------------------------------------------------
    always_comb begin
        // bias negatives so the shift truncates toward zero
        biased  = s1_prod + ((s1_prod < 0) ? TRUNC_BIAS : 64'sd0);
        high    = s1_sat ? QINT_MAX : qoffset_t'(biased >>> 31);
        mask    = (32'sd1 <<< s1_rsh) - 32'sd1;
        rem     = high & mask;
        // half away from zero
        thresh  = (mask >>> 1) + ((high < 0) ? 32'sd1 : 32'sd0);
        rounded = (high >>> s1_rsh) + ((rem > thresh) ? 32'sd1 : 32'sd0);
    end

    always_ff @(posedge clk) begin
        y_o <= rounded;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            s1_valid <= valid_i;
            valid_o  <= s1_valid;
        end
    end

    a_shift_range: assert property (@(posedge clk) disable iff (!rst)
        valid_i |-> (shift_i >= -31) && (shift_i <= 30))
        else $error("quant_mult shift out of range: %0d", shift_i);

endmodule

// ==== design/addsub_lane.sv ====
`timescale 1ns/100ps

module addsub_lane
    import ew_data_pkg::*, ew_quant_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,
    input  logic     sub_i,
    input  elem_t    a_i,
    input  elem_t    b_i,
    input  qoffset_t in1_offset_i,
    input  qoffset_t in2_offset_i,
    input  qoffset_t out_offset_i,
    input  qshift_t  left_shift_i,
    input  qshift_t  in1_shift_i,
    input  qshift_t  in2_shift_i,
    input  qshift_t  out_shift_i,
    input  qmult_t   in1_mult_i,
    input  qmult_t   in2_mult_i,
    input  qmult_t   out_mult_i,
    input  qlimit_t  act_min_i,
    input  qlimit_t  act_max_i,
    output logic     valid_o,
    output elem_t    y_o
);

    logic       s1_valid;
    logic       s1_sub;
    qoffset_t   s1_a;
    qoffset_t   s1_b;

    logic       qa_valid;
    logic       qb_valid;
    qoffset_t   qa_y;
    qoffset_t   qb_y;
    logic [1:0] sub_pipe;

    logic       s4_valid;
    qoffset_t   s4_sum;
    qoffset_t   out_y;

    // offset and common left shift
    always_ff @(posedge clk) begin
        s1_a   <= (qoffset_t'(a_i) + in1_offset_i) <<< left_shift_i[4:0];
        s1_b   <= (qoffset_t'(b_i) + in2_offset_i) <<< left_shift_i[4:0];
        s1_sub <= sub_i;
    end

    // rescale both terms in parallel
    quant_mult u_qm_a (
        .clk     (clk),
        .rst     (rst),
        .valid_i (s1_valid),
        .x_i     (s1_a),
        .mult_i  (in1_mult_i),
        .shift_i (in1_shift_i),
        .valid_o (qa_valid),
        .y_o     (qa_y)
    );

    quant_mult u_qm_b (
        .clk     (clk),
        .rst     (rst),
        .valid_i (s1_valid),
        .x_i     (s1_b),
        .mult_i  (in2_mult_i),
        .shift_i (in2_shift_i),
        .valid_o (qb_valid),
        .y_o     (qb_y)
    );

    // op flag follows the data through the rescale
    always_ff @(posedge clk) begin
        sub_pipe <= {sub_pipe[0], s1_sub};
        s4_sum   <= sub_pipe[1] ? (qa_y - qb_y) : (qa_y + qb_y);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s4_valid <= 1'b0;
        end else begin
            s1_valid <= valid_i;
            s4_valid <= qa_valid & qb_valid;
        end
    end

    // output rescale, its register is the last stage
    quant_mult u_qm_out (
        .clk     (clk),
        .rst     (rst),
        .valid_i (s4_valid),
        .x_i     (s4_sum),
        .mult_i  (out_mult_i),
        .shift_i (out_shift_i),
        .valid_o (valid_o),
        .y_o     (out_y)
    );

    assign y_o = elem_t'(clamp_act(out_y + out_offset_i, act_min_i, act_max_i));

    a_act_window: assert property (@(posedge clk) disable iff (!rst)
        valid_i |-> act_min_i <= act_max_i)
        else $error("addsub_lane activation min above max");

endmodule

// ==== design/mul_lane.sv ====
`timescale 1ns/100ps

module mul_lane
    import ew_data_pkg::*, ew_quant_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,
    input  elem_t    a_i,
    input  elem_t    b_i,
    input  qoffset_t in1_offset_i,
    input  qoffset_t in2_offset_i,
    input  qoffset_t out_offset_i,
    input  qmult_t   out_mult_i,
    input  qshift_t  out_shift_i,
    input  qlimit_t  act_min_i,
    input  qlimit_t  act_max_i,
    output logic     valid_o,
    output elem_t    y_o
);

    logic     s1_valid;
    qoffset_t s1_prod;
    logic     qm_valid;
    qoffset_t qm_y;

    // product of the offset inputs
    always_ff @(posedge clk) begin
        s1_prod <= (qoffset_t'(a_i) + in1_offset_i) * (qoffset_t'(b_i) + in2_offset_i);
    end

    quant_mult u_qm (
        .clk     (clk),
        .rst     (rst),
        .valid_i (s1_valid),
        .x_i     (s1_prod),
        .mult_i  (out_mult_i),
        .shift_i (out_shift_i),
        .valid_o (qm_valid),
        .y_o     (qm_y)
    );

    // output offset and clamp, registered
    always_ff @(posedge clk) begin
        y_o <= elem_t'(clamp_act(qm_y + out_offset_i, act_min_i, act_max_i));
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            s1_valid <= valid_i;
            valid_o  <= qm_valid;
        end
    end

endmodule

// ==== design/ew_ctrl.sv ====
`timescale 1ns/100ps
`include "ew_config.svh"

module ew_ctrl
    import ew_data_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   init_i,
    input  logic   en_i,
    input  ew_op_e op_i,
    input  addr_t  out_count_i,
    input  logic   result_valid_i,
    output addr_t  addr_o,
    output logic   sram_en_o,
    output ew_op_e beat_op_o,
    output cnt_t   beat_count_o,
    output cnt_t   result_count_o
);

    logic beat;

    assign beat = en_i && (op_i != OP_NONE);

    // no reads past the end of the tensor
    assign sram_en_o = beat && (addr_o < out_count_i);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            addr_o         <= '0;
            beat_op_o      <= OP_NONE;
            beat_count_o   <= '0;
            result_count_o <= '0;
        end else if (init_i) begin
            addr_o         <= '0;
            beat_op_o      <= OP_NONE;
            beat_count_o   <= '0;
            result_count_o <= '0;
        end else begin
            // op lines up with the sram data one cycle later
            beat_op_o <= beat ? op_i : OP_NONE;
            if (beat) begin
                addr_o       <= addr_o + addr_t'(`EW_ADDR_STEP);
                beat_count_o <= beat_count_o + cnt_t'(1);
            end
            if (result_valid_i) begin
                result_count_o <= result_count_o + cnt_t'(1);
            end
        end
    end

    a_op_stable: assert property (@(posedge clk) disable iff (!rst)
        (en_i && $past(en_i)) |-> $stable(op_i))
        else $error("ew_ctrl op changed during a run");

endmodule

// ==== design/element_wise.sv ====
`timescale 1ns/100ps
`include "ew_config.svh"

module element_wise
    import ew_data_pkg::*, ew_quant_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     init_i,
    input  logic     en_i,
    input  ew_op_e   op_i,
    input  addr_t    out_count_i,
    input  word_t    data_i,
    input  word_t    weight_i,
    input  qoffset_t in1_offset_i,
    input  qoffset_t in2_offset_i,
    input  qoffset_t out_offset_i,
    input  qshift_t  left_shift_i,
    input  qshift_t  in1_shift_i,
    input  qshift_t  in2_shift_i,
    input  qshift_t  out_shift_i,
    input  qmult_t   in1_mult_i,
    input  qmult_t   in2_mult_i,
    input  qmult_t   out_mult_i,
    input  qlimit_t  act_min_i,
    input  qlimit_t  act_max_i,
    output addr_t    addr_o,
    output logic     sram_en_o,
    output word_t    data_o,
    output logic     valid_o,
    output cnt_t     beat_count_o,
    output cnt_t     result_count_o
);

    ew_op_e              beat_op;
    logic                as_fire;
    logic                as_sub;
    logic                mul_fire;
    logic [`EW_LANES-1:0] as_valid;
    logic [`EW_LANES-1:0] mul_valid;
    word_t               as_word;
    word_t               mul_word;

    ew_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .init_i         (init_i),
        .en_i           (en_i),
        .op_i           (op_i),
        .out_count_i    (out_count_i),
        .result_valid_i (valid_o),
        .addr_o         (addr_o),
        .sram_en_o      (sram_en_o),
        .beat_op_o      (beat_op),
        .beat_count_o   (beat_count_o),
        .result_count_o (result_count_o)
    );

    // op decode into lane valids
    assign as_fire  = (beat_op == OP_ADD) || (beat_op == OP_SUB);
    assign as_sub   = (beat_op == OP_SUB);
    assign mul_fire = (beat_op == OP_MUL);

    // ------------------------------------------------------------------------
    // lanes
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < `EW_LANES; i++) begin : g_lane
        addsub_lane u_addsub (
            .clk          (clk),
            .rst          (rst),
            .valid_i      (as_fire),
            .sub_i        (as_sub),
            .a_i          (data_i[i*`EW_ELEM_W +: `EW_ELEM_W]),
            .b_i          (weight_i[i*`EW_ELEM_W +: `EW_ELEM_W]),
            .in1_offset_i (in1_offset_i),
            .in2_offset_i (in2_offset_i),
            .out_offset_i (out_offset_i),
            .left_shift_i (left_shift_i),
            .in1_shift_i  (in1_shift_i),
            .in2_shift_i  (in2_shift_i),
            .out_shift_i  (out_shift_i),
            .in1_mult_i   (in1_mult_i),
            .in2_mult_i   (in2_mult_i),
            .out_mult_i   (out_mult_i),
            .act_min_i    (act_min_i),
            .act_max_i    (act_max_i),
            .valid_o      (as_valid[i]),
            .y_o          (as_word[i*`EW_ELEM_W +: `EW_ELEM_W])
        );

        mul_lane u_mul (
            .clk          (clk),
            .rst          (rst),
            .valid_i      (mul_fire),
            .a_i          (data_i[i*`EW_ELEM_W +: `EW_ELEM_W]),
            .b_i          (weight_i[i*`EW_ELEM_W +: `EW_ELEM_W]),
            .in1_offset_i (in1_offset_i),
            .in2_offset_i (in2_offset_i),
            .out_offset_i (out_offset_i),
            .out_mult_i   (out_mult_i),
            .out_shift_i  (out_shift_i),
            .act_min_i    (act_min_i),
            .act_max_i    (act_max_i),
            .valid_o      (mul_valid[i]),
            .y_o          (mul_word[i*`EW_ELEM_W +: `EW_ELEM_W])
        );
    end

    // all lanes run in step, lane 0 speaks for the word
    assign valid_o = as_valid[0] | mul_valid[0];

    always_comb begin
        if (as_valid[0]) begin
            data_o = as_word;
        end else if (mul_valid[0]) begin
            data_o = mul_word;
        end else begin
            data_o = '0;
        end
    end

    a_path_excl: assert property (@(posedge clk) disable iff (!rst)
        !((|as_valid) && (|mul_valid)))
        else $error("add/sub and mul results collide");

endmodule

// ==== include/ew_ref_model.svh ====
`ifndef EW_REF_MODEL_SVH
`define EW_REF_MODEL_SVH

// rescale by q31 multiplier and signed shift
function automatic qoffset_t ref_rescale(qoffset_t x, qmult_t m, qshift_t s);
    qoffset_t xs;
    longint   p;
    qoffset_t hi;
    qoffset_t mask;
    qoffset_t rem;
    qoffset_t thr;
    int       rsh;
    xs  = (s > 0) ? qoffset_t'(x <<< s) : x;
    rsh = (s < 0) ? -s : 0;
    if ((xs == QINT_MIN) && (m == QINT_MIN)) begin
        hi = QINT_MAX;
    end else begin
        p  = longint'(xs) * longint'(m);
        p  = p + ((p >= 0) ? longint'(1 << 30) : longint'(1 - (1 << 30)));
        hi = qoffset_t'(p / (longint'(1) << 31));
    end
    mask = qoffset_t'((longint'(1) << rsh) - 1);
    rem  = hi & mask;
    thr  = (mask >>> 1) + ((hi < 0) ? 1 : 0);
    return (hi >>> rsh) + ((rem > thr) ? 1 : 0);
endfunction

// saturate into the activation window
function automatic qoffset_t ref_clamp(qoffset_t v, qlimit_t lo, qlimit_t hi);
    qoffset_t r;
    r = (v > hi) ? hi : v;
    r = (r < lo) ? lo : r;
    return r;
endfunction

// one lane of add or of sub when sub is set
function automatic elem_t ref_addsub(elem_t a, elem_t b, logic sub,
    qoffset_t off1, qoffset_t off2, qoffset_t off_out, qshift_t lsh,
    qshift_t sh1, qshift_t sh2, qshift_t sh_out,
    qmult_t m1, qmult_t m2, qmult_t m_out, qlimit_t lo, qlimit_t hi);
    qoffset_t s1;
    qoffset_t s2;
    qoffset_t r;
    s1 = ref_rescale(qoffset_t'((qoffset_t'(a) + off1) <<< lsh), m1, sh1);
    s2 = ref_rescale(qoffset_t'((qoffset_t'(b) + off2) <<< lsh), m2, sh2);
    r  = sub ? (s1 - s2) : (s1 + s2);
    r  = ref_rescale(r, m_out, sh_out) + off_out;
    return elem_t'(ref_clamp(r, lo, hi));
endfunction

// one lane of mul
function automatic elem_t ref_mul(elem_t a, elem_t b,
    qoffset_t off1, qoffset_t off2, qoffset_t off_out,
    qmult_t m_out, qshift_t sh_out, qlimit_t lo, qlimit_t hi);
    qoffset_t r;
    r = (qoffset_t'(a) + off1) * (qoffset_t'(b) + off2);
    r = ref_rescale(r, m_out, sh_out) + off_out;
    return elem_t'(ref_clamp(r, lo, hi));
endfunction

`endif

// ==== tb/tb_element_wise.sv ====
`timescale 1ns/100ps
`include "ew_config.svh"

module tb_element_wise
    import ew_data_pkg::*, ew_quant_pkg::*;
();

    `include "ew_ref_model.svh"

    logic     clk = 1'b0;
    logic     rst;
    logic     init_i;
    logic     en_i;
    ew_op_e   op_i;
    addr_t    out_count_i;
    word_t    data_i = '0;
    word_t    weight_i = '0;
    qoffset_t in1_offset_i;
    qoffset_t in2_offset_i;
    qoffset_t out_offset_i;
    qshift_t  left_shift_i;
    qshift_t  in1_shift_i;
    qshift_t  in2_shift_i;
    qshift_t  out_shift_i;
    qmult_t   in1_mult_i;
    qmult_t   in2_mult_i;
    qmult_t   out_mult_i;
    qlimit_t  act_min_i;
    qlimit_t  act_max_i;
    addr_t    addr_o;
    logic     sram_en_o;
    word_t    data_o;
    logic     valid_o;
    cnt_t     beat_count_o;
    cnt_t     result_count_o;

    logic [31:0] rng = 32'h7e7a;
    word_t       exp_q[$];
    word_t       head_word = '0;
    logic        has_exp = 1'b0;
    logic        accepted;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          sram_en_seen = 0;
    int          valid_seen = 0;
    bit          timed_out = 1'b0;

    always #20 clk = ~clk;

    element_wise dut0 (
        .clk            (clk),
        .rst            (rst),
        .init_i         (init_i),
        .en_i           (en_i),
        .op_i           (op_i),
        .out_count_i    (out_count_i),
        .data_i         (data_i),
        .weight_i       (weight_i),
        .in1_offset_i   (in1_offset_i),
        .in2_offset_i   (in2_offset_i),
        .out_offset_i   (out_offset_i),
        .left_shift_i   (left_shift_i),
        .in1_shift_i    (in1_shift_i),
        .in2_shift_i    (in2_shift_i),
        .out_shift_i    (out_shift_i),
        .in1_mult_i     (in1_mult_i),
        .in2_mult_i     (in2_mult_i),
        .out_mult_i     (out_mult_i),
        .act_min_i      (act_min_i),
        .act_max_i      (act_max_i),
        .addr_o         (addr_o),
        .sram_en_o      (sram_en_o),
        .data_o         (data_o),
        .valid_o        (valid_o),
        .beat_count_o   (beat_count_o),
        .result_count_o (result_count_o)
    );

    assign accepted = en_i && (op_i != OP_NONE);

    // ------------------------------------------------------------------------
    // random numbers and expected words
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int rand_range(int lo, int hi);
        return lo + int'(next_rand() % 32'(hi - lo + 1));
    endfunction

    // q31 multiplier in [0.5, 1)
    function automatic qmult_t rand_mult();
        return qmult_t'(32'h4000_0000 | (next_rand() & 32'h3fff_ffff));
    endfunction

    function automatic word_t expect_word(ew_op_e op, word_t d, word_t w);
        word_t r;
        elem_t a;
        elem_t b;
        r = '0;
        for (int i = 0; i < `EW_LANES; i++) begin
            a = elem_t'(d[i*`EW_ELEM_W +: `EW_ELEM_W]);
            b = elem_t'(w[i*`EW_ELEM_W +: `EW_ELEM_W]);
            if (op == OP_MUL) begin
                r[i*`EW_ELEM_W +: `EW_ELEM_W] = ref_mul(a, b, in1_offset_i, in2_offset_i,
                    out_offset_i, out_mult_i, out_shift_i, act_min_i, act_max_i);
            end else begin
                r[i*`EW_ELEM_W +: `EW_ELEM_W] = ref_addsub(a, b, op == OP_SUB,
                    in1_offset_i, in2_offset_i, out_offset_i, left_shift_i,
                    in1_shift_i, in2_shift_i, out_shift_i,
                    in1_mult_i, in2_mult_i, out_mult_i, act_min_i, act_max_i);
            end
        end
        return r;
    endfunction

    function automatic bit in_window(word_t w, qlimit_t lo, qlimit_t hi);
        qlimit_t v;
        bit      ok;
        ok = 1'b1;
        for (int i = 0; i < `EW_LANES; i++) begin
            v = qlimit_t'(elem_t'(w[i*`EW_ELEM_W +: `EW_ELEM_W]));
            if ((v < lo) || (v > hi)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic bit outputs_idle(logic v, logic en, addr_t a, cnt_t bc, cnt_t rc);
        return !v && !en && (a == '0) && (bc == '0) && (rc == '0);
    endfunction

    // sram answers one cycle after the beat and holds its output when not enabled
    always @(posedge clk) begin
        word_t nd;
        word_t nw;
        if (valid_o && (exp_q.size() > 0)) begin
            void'(exp_q.pop_front());
        end
        if (accepted) begin
            nd = data_i;
            nw = weight_i;
            if (sram_en_o) begin
                nd[63:32] = next_rand();
                nd[31:0]  = next_rand();
                nw[63:32] = next_rand();
                nw[31:0]  = next_rand();
            end
            data_i   <= nd;
            weight_i <= nw;
            exp_q.push_back(expect_word(op_i, nd, nw));
        end
        head_word <= (exp_q.size() > 0) ? exp_q[0] : '0;
        has_exp   <= (exp_q.size() > 0);
        if (sram_en_o) begin
            sram_en_seen++;
        end
        if (valid_o) begin
            valid_seen++;
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_result: assert property (@(posedge clk) disable iff (!rst)
        valid_o |-> (has_exp && (data_o == head_word)))
        else begin
            $display("FAILED %0t: data_o %h, expected %h", $time, $sampled(data_o),
                $sampled(head_word));
            errors++;
        end

    a_addsub_latency: assert property (@(posedge clk) disable iff (!rst)
        (accepted && (op_i != OP_MUL)) |-> ##(`EW_ADDSUB_LAT + 1) valid_o)
        else begin
            $display("FAILED %0t: add/sub result missing 7 cycles after its beat", $time);
            errors++;
        end

    a_mul_latency: assert property (@(posedge clk) disable iff (!rst)
        (accepted && (op_i == OP_MUL)) |-> ##(`EW_MUL_LAT + 1) valid_o)
        else begin
            $display("FAILED %0t: mul result missing 5 cycles after its beat", $time);
            errors++;
        end

    a_clamp: assert property (@(posedge clk) disable iff (!rst)
        valid_o |-> in_window(data_o, act_min_i, act_max_i))
        else begin
            $display("FAILED %0t: data_o %h outside [%0d, %0d]", $time, $sampled(data_o),
                act_min_i, act_max_i);
            errors++;
        end

    a_addr_step: assert property (@(posedge clk) disable iff (!rst)
        (accepted && !init_i) |=> (addr_o == $past(addr_o) + addr_t'(`EW_ADDR_STEP))
            && (beat_count_o == $past(beat_count_o) + cnt_t'(1)))
        else begin
            $display("FAILED %0t: addr_o %0d or beat_count_o %0d did not advance", $time,
                $sampled(addr_o), $sampled(beat_count_o));
            errors++;
        end

    a_result_count: assert property (@(posedge clk) disable iff (!rst)
        (valid_o && !init_i) |=> (result_count_o == $past(result_count_o) + cnt_t'(1)))
        else begin
            $display("FAILED %0t: result_count_o %0d missed a result", $time,
                $sampled(result_count_o));
            errors++;
        end

    a_sram_window: assert property (@(posedge clk) disable iff (!rst)
        sram_en_o |-> (addr_o < out_count_i))
        else begin
            $display("FAILED %0t: sram_en_o high at addr %0d", $time, $sampled(addr_o));
            errors++;
        end

    a_init_clear: assert property (@(posedge clk) disable iff (!rst)
        init_i |=> outputs_idle(valid_o, sram_en_o, addr_o, beat_count_o, result_count_o))
        else begin
            $display("FAILED %0t: outputs not cleared by init_i", $time);
            errors++;
        end

    // ------------------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------------------
    task automatic setup_run(qlimit_t lo, qlimit_t hi, int osh_lo, int osh_hi, int ocount);
        @(posedge clk);
        op_i         <= OP_NONE;
        in1_offset_i <= rand_range(-128, 127);
        in2_offset_i <= rand_range(-128, 127);
        out_offset_i <= rand_range(-20, 20);
        left_shift_i <= 20;
        in1_shift_i  <= rand_range(-4, -1);
        in2_shift_i  <= rand_range(-4, -1);
        out_shift_i  <= rand_range(osh_lo, osh_hi);
        in1_mult_i   <= rand_mult();
        in2_mult_i   <= rand_mult();
        out_mult_i   <= rand_mult();
        act_min_i    <= lo;
        act_max_i    <= hi;
        out_count_i  <= addr_t'(ocount);
        init_i       <= 1'b1;
        @(posedge clk);
        init_i <= 1'b0;
    endtask

    task automatic run_beats(ew_op_e op, int n);
        @(posedge clk);
        op_i <= op;
        en_i <= 1'b1;
        repeat (n) @(posedge clk);
        en_i <= 1'b0;
    endtask

    task automatic wait_drain(int limit);
        int n;
        n = 0;
        @(negedge clk);
        while ((exp_q.size() != 0) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d result words never arrived", exp_q.size());
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-6s ok", name);
        end else begin
            tests_failed++;
            $display("test %-6s %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic op_test(string name, ew_op_e op, qlimit_t lo, qlimit_t hi,
        int osh_lo, int osh_hi);
        int e0;
        e0 = errors;
        setup_run(lo, hi, osh_lo, osh_hi, 4096);
        run_beats(op, 24);
        wait_drain(64);
        report_test(name, e0);
    endtask

    // ten beats against a five-beat tensor
    task automatic count_test();
        int e0;
        int en0;
        int v0;
        e0 = errors;
        setup_run(-128, 127, -20, -19, 40);
        @(negedge clk);
        en0 = sram_en_seen;
        v0  = valid_seen;
        run_beats(OP_ADD, 10);
        wait_drain(64);
        assert (sram_en_seen - en0 == 5) else begin
            $display("FAILED %0t: sram_en_o high %0d times, expected 5", $time,
                sram_en_seen - en0);
            errors++;
        end
        assert ((addr_o == addr_t'(80)) && (beat_count_o == cnt_t'(10))) else begin
            $display("FAILED %0t: addr_o %0d beat_count_o %0d, expected 80 and 10", $time,
                addr_o, beat_count_o);
            errors++;
        end
        assert (result_count_o == cnt_t'(valid_seen - v0)) else begin
            $display("FAILED %0t: result_count_o %0d, valid_o pulses %0d", $time,
                result_count_o, valid_seen - v0);
            errors++;
        end
        @(posedge clk);
        init_i <= 1'b1;
        @(posedge clk);
        init_i <= 1'b0;
        @(negedge clk);
        assert (outputs_idle(valid_o, sram_en_o, addr_o, beat_count_o, result_count_o))
        else begin
            $display("FAILED %0t: counters and address not cleared by init_i", $time);
            errors++;
        end
        report_test("count", e0);
    endtask

    initial begin
        int e0;
        rst          <= 1'b0;
        init_i       <= 1'b0;
        en_i         <= 1'b0;
        op_i         <= OP_NONE;
        out_count_i  <= '0;
        in1_offset_i <= '0;
        in2_offset_i <= '0;
        out_offset_i <= '0;
        left_shift_i <= '0;
        in1_shift_i  <= '0;
        in2_shift_i  <= '0;
        out_shift_i  <= '0;
        in1_mult_i   <= '0;
        in2_mult_i   <= '0;
        out_mult_i   <= '0;
        act_min_i    <= -128;
        act_max_i    <= 127;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        e0 = errors;
        assert (outputs_idle(valid_o, sram_en_o, addr_o, beat_count_o, result_count_o))
        else begin
            $display("FAILED %0t: outputs not idle after reset", $time);
            errors++;
        end
        report_test("reset", e0);
        if (!timed_out) op_test("add", OP_ADD, -128, 127, -20, -19);
        // narrow window so many lanes clamp
        if (!timed_out) op_test("sub", OP_SUB, -40, 40, -20, -19);
        if (!timed_out) op_test("mul", OP_MUL, -128, 127, -8, -6);
        if (!timed_out) count_test();
        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if ((errors == 0) && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== element_wise.f ====
+incdir+include
design/ew_data_pkg.sv
design/ew_quant_pkg.sv
design/quant_mult.sv
design/addsub_lane.sv
design/mul_lane.sv
design/ew_ctrl.sv
design/element_wise.sv
tb/tb_element_wise.sv

// ==== Makefile ====
# Verilator build and run for the element-wise unit

VERILATOR ?= verilator
TOP       ?= tb_element_wise
FILELIST  ?= element_wise.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
